/* Makefile */
# Verilator build and run for the FM register front end.

VERILATOR ?= verilator
TOP       ?= tb_fm_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SOURCES   := $(wildcard hdl/*.sv testbench/*.sv)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $$fatal in the testbench gives a nonzero exit status.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/fm_bus_sync.sv */
`timescale 1ns/1ns

module fm_bus_sync (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  logic       cs_n,
	input  logic       wr_n,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	input  logic       flag_a,
	input  logic       flag_b,
	output logic [7:0] dout,
	output logic       fm_tick,
	output logic       rst_int,
	fm_wr_if.sync_mp   bus
);

	// Prescaler count, advances on clk_en.
	logic [2:0] cnt;
	// High in the clk_en cycle just before an FM tick.
	logic       tick_next;
	// CPU side busy flag, seen in status bit 7.
	logic       busy;
	// Two-stage history of busy_mmr, newest in bit 0.
	logic [1:0] busy_mmr_sh;
	logic       write_raw;
	// Latched CPU write waiting for the FM domain.
	logic       write_copy;
	logic [1:0] addr_copy;
	logic [7:0] din_copy;

	// ##################################################
	// FM tick prescaler and internal reset.
	// ##################################################

	assign tick_next = clk_en && (cnt == 3'(fm_pkg::FM_DIV - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt     <= '0;
			fm_tick <= 1'b0;
			rst_int <= 1'b1;
		end else begin
			// Tick is registered so it lasts one clk cycle.
			fm_tick <= tick_next;
			if (clk_en)
				cnt <= (cnt == 3'(fm_pkg::FM_DIV - 1)) ? 3'd0 : cnt + 3'd1;
			// FM domain leaves reset at the first tick.
			if (fm_tick)
				rst_int <= 1'b0;
		end
	end

	// ##################################################
	// CPU write latch.
	// ##################################################

	assign write_raw = !cs_n && !wr_n;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy        <= 1'b0;
			write_copy  <= 1'b0;
			busy_mmr_sh <= 2'b00;
		end else if (clk_en) begin
			busy_mmr_sh <= {busy_mmr_sh[0], bus.busy_mmr};
			if (write_raw && !busy) begin
				busy       <= 1'b1;
				write_copy <= 1'b1;
			end else begin
				// Control module has taken the write.
				if (bus.busy_mmr)
					write_copy <= 1'b0;
				// Falling edge of busy_mmr ends the CPU busy.
				if (busy && busy_mmr_sh == 2'b10)
					busy <= 1'b0;
			end
		end
	end

	// Address and data are only captured with an accepted write.
	always_ff @(posedge clk) begin
		if (clk_en && write_raw && !busy) begin
			addr_copy <= addr;
			din_copy  <= din;
		end
	end

	// Present the pending write in the tick cycle, held back while in internal reset.
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			bus.write <= 1'b0;
		else
			bus.write <= tick_next && write_copy && !rst_int;
	end

	always_ff @(posedge clk) begin
		if (tick_next) begin
			bus.addr <= addr_copy;
			bus.din  <= din_copy;
		end
	end

	// Status byte.
	assign dout = {busy, 5'b00000, flag_b, flag_a};

endmodule

/* hdl/fm_core_top.sv */
`timescale 1ns/1ns

module fm_core_top (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  logic       cs_n,
	input  logic       wr_n,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	output logic [7:0] dout,
	output logic [1:0] irq_flags
);

	logic                      fm_tick;
	logic                      rst_int;
	logic [fm_pkg::TMRA_W-1:0] tmra_val;
	logic [fm_pkg::TMRB_W-1:0] tmrb_val;
	logic                      load_a;
	logic                      load_b;
	logic                      en_a;
	logic                      en_b;
	logic                      clr_a;
	logic                      clr_b;
	logic                      ovf_a;
	logic                      ovf_b;
	logic                      flag_a;
	logic                      flag_b;

	fm_wr_if u_wr_if ();

	fm_bus_sync u_sync (
		.clk     (clk),
		.rst     (rst),
		.clk_en  (clk_en),
		.cs_n    (cs_n),
		.wr_n    (wr_n),
		.addr    (addr),
		.din     (din),
		.flag_a  (flag_a),
		.flag_b  (flag_b),
		.dout    (dout),
		.fm_tick (fm_tick),
		.rst_int (rst_int),
		.bus     (u_wr_if.sync_mp)
	);

	fm_reg_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst_int),
		.fm_tick  (fm_tick),
		.bus      (u_wr_if.ctrl_mp),
		.tmra_val (tmra_val),
		.tmrb_val (tmrb_val),
		.load_a   (load_a),
		.load_b   (load_b),
		.en_a     (en_a),
		.en_b     (en_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b)
	);

	// Timer A steps on every FM tick.
	fm_timer #(.WIDTH(fm_pkg::TMRA_W), .PRESCALE(1)) u_tmra (
		.clk     (clk),
		.rst     (rst_int),
		.fm_tick (fm_tick),
		.load    (load_a),
		.val     (tmra_val),
		.ovf     (ovf_a)
	);

	fm_timer #(.WIDTH(fm_pkg::TMRB_W), .PRESCALE(fm_pkg::TMRB_PRESCALE)) u_tmrb (
		.clk     (clk),
		.rst     (rst_int),
		.fm_tick (fm_tick),
		.load    (load_b),
		.val     (tmrb_val),
		.ovf     (ovf_b)
	);

	// ##################################################
	// Status flags.
	// ##################################################

	// Clear wins over a coinciding overflow.
	always_ff @(posedge clk or posedge rst_int) begin
		if (rst_int) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (clr_a)
				flag_a <= 1'b0;
			else if (ovf_a && en_a)
				flag_a <= 1'b1;
			if (clr_b)
				flag_b <= 1'b0;
			else if (ovf_b && en_b)
				flag_b <= 1'b1;
		end
	end

	assign irq_flags = {flag_b, flag_a};

endmodule

/* hdl/fm_pkg.sv */
package fm_pkg;

	// ##################################################
	// Clock division and timing.
	// ##################################################

	// System clock enables per FM tick.
	localparam int FM_DIV = 6;
	// FM ticks that busy_mmr stays up after a write.
	localparam int BUSY_TICKS = 4;
	// FM ticks per timer B step.
	localparam int TMRB_PRESCALE = 16;

	// Timer widths.
	localparam int TMRA_W = 10;
	localparam int TMRB_W = 8;

	// ##################################################
	// Register map.
	// ##################################################

	// Timer A high 8 bits, then low 2 bits.
	localparam logic [7:0] REG_TMRA_HI  = 8'h24;
	localparam logic [7:0] REG_TMRA_LO  = 8'h25;
	localparam logic [7:0] REG_TMRB     = 8'h26;
	localparam logic [7:0] REG_TMR_CTRL = 8'h27;

	// Bit positions in the timer control register.
	localparam int CTRL_LOAD_A = 0;
	localparam int CTRL_LOAD_B = 1;
	localparam int CTRL_EN_A   = 2;
	localparam int CTRL_EN_B   = 3;
	localparam int CTRL_RST_A  = 4;
	localparam int CTRL_RST_B  = 5;

	// Sequencer phase, data is only accepted once an address is selected.
	typedef enum logic {WR_ADDR, WR_DATA} wr_phase_e;

	// Meaning of the CPU address port, taken from addr bit 0.
	typedef enum logic {OP_ADDR = 1'b0, OP_DATA = 1'b1} bus_op_e;

endpackage

/* hdl/fm_reg_ctrl.sv */
`timescale 1ns/1ns

module fm_reg_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fm_tick,
	fm_wr_if.ctrl_mp                  bus,
	output logic [fm_pkg::TMRA_W-1:0] tmra_val,
	output logic [fm_pkg::TMRB_W-1:0] tmrb_val,
	output logic                      load_a,
	output logic                      load_b,
	output logic                      en_a,
	output logic                      en_b,
	output logic                      clr_a,
	output logic                      clr_b
);

	fm_pkg::wr_phase_e phase;
	fm_pkg::bus_op_e   op;
	// Write captured on its arrival tick, applied on the next one.
	logic              wr_pend;
	logic [1:0]        wr_addr_q;
	logic [7:0]        wr_din_q;
	// Register selected by the last address write.
	logic [7:0]        sel_addr;
	logic [2:0]        busy_cnt;
	// Pending write targets the first bank.
	logic              apply;

	assign op    = fm_pkg::bus_op_e'(wr_addr_q[0]);
	assign apply = wr_pend && !wr_addr_q[1];

	// Busy while the down-counter runs.
	assign bus.busy_mmr = (busy_cnt != 3'd0);

	always_ff @(posedge clk) begin
		if (bus.write) begin
			wr_addr_q <= bus.addr;
			wr_din_q  <= bus.din;
		end
	end

	always_ff @(posedge clk) begin
		if (fm_tick && apply && op == fm_pkg::OP_ADDR)
			sel_addr <= wr_din_q;
	end

	// ##################################################
	// Sequencer, busy timer and timer register decode.
	// ##################################################

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase    <= fm_pkg::WR_ADDR;
			wr_pend  <= 1'b0;
			busy_cnt <= 3'd0;
			tmra_val <= '0;
			tmrb_val <= '0;
			load_a   <= 1'b0;
			load_b   <= 1'b0;
			en_a     <= 1'b0;
			en_b     <= 1'b0;
			clr_a    <= 1'b0;
			clr_b    <= 1'b0;
		end else if (fm_tick) begin
			wr_pend <= bus.write;
			// Load and clear last one FM period.
			load_a  <= 1'b0;
			load_b  <= 1'b0;
			clr_a   <= 1'b0;
			clr_b   <= 1'b0;
			// Any write restarts busy, address writes too.
			if (bus.write)
				busy_cnt <= 3'(fm_pkg::BUSY_TICKS);
			else if (busy_cnt != 3'd0)
				busy_cnt <= busy_cnt - 3'd1;
			if (apply) begin
				if (op == fm_pkg::OP_ADDR) begin
					phase <= fm_pkg::WR_DATA;
				end else if (phase == fm_pkg::WR_DATA) begin
					case (sel_addr)
						fm_pkg::REG_TMRA_HI: tmra_val[fm_pkg::TMRA_W-1:2] <= wr_din_q;
						fm_pkg::REG_TMRA_LO: tmra_val[1:0] <= wr_din_q[1:0];
						fm_pkg::REG_TMRB:    tmrb_val <= wr_din_q;
						fm_pkg::REG_TMR_CTRL: begin
							load_a <= wr_din_q[fm_pkg::CTRL_LOAD_A];
							load_b <= wr_din_q[fm_pkg::CTRL_LOAD_B];
							en_a   <= wr_din_q[fm_pkg::CTRL_EN_A];
							en_b   <= wr_din_q[fm_pkg::CTRL_EN_B];
							clr_a  <= wr_din_q[fm_pkg::CTRL_RST_A];
							clr_b  <= wr_din_q[fm_pkg::CTRL_RST_B];
						end
						// Unknown registers are ignored.
						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* hdl/fm_timer.sv */
`timescale 1ns/1ns

module fm_timer #(
	parameter int WIDTH    = 10,
	parameter int PRESCALE = 1
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             fm_tick,
	input  logic             load,
	input  logic [WIDTH-1:0] val,
	output logic             ovf
);

	// Prescaler wide enough to hold PRESCALE-1.
	typedef logic [$clog2(PRESCALE + 1)-1:0] pre_t;

	logic [WIDTH-1:0] cnt;
	pre_t             pre_cnt;
	// Stopped after reset until the first load.
	logic             running;
	// One timer step, the last tick of a prescaler round.
	logic             step;

	assign step = fm_tick && running && (pre_cnt == pre_t'(PRESCALE - 1));

	// ##################################################
	// Counter with reload on overflow.
	// ##################################################

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt     <= '0;
			pre_cnt <= '0;
			running <= 1'b0;
			ovf     <= 1'b0;
		end else begin
			// Overflow is a single cycle pulse.
			ovf <= 1'b0;
			if (fm_tick && load) begin
				// Start from the loaded value, first step a full round later.
				cnt     <= val;
				pre_cnt <= '0;
				running <= 1'b1;
			end else if (fm_tick && running) begin
				if (step)
					pre_cnt <= '0;
				else
					pre_cnt <= pre_cnt + 1'b1;
				if (step) begin
					if (&cnt) begin
						// Passed all-ones.
						ovf <= 1'b1;
						cnt <= val;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* hdl/fm_wr_if.sv */
`timescale 1ns/1ns

// Register write handed from the bus synchronizer to the control module.
interface fm_wr_if;

	// One clk cycle wide, only ever on an FM tick.
	logic       write;
	// CPU port address and data, valid with write.
	logic [1:0] addr;
	logic [7:0] din;
	// Register busy, back to the synchronizer.
	logic       busy_mmr;

	modport sync_mp (output write, output addr, output din, input busy_mmr);

	modport ctrl_mp (input write, input addr, input din, output busy_mmr);

endinterface

/* tb.f */
hdl/fm_pkg.sv
hdl/fm_wr_if.sv
hdl/fm_bus_sync.sv
hdl/fm_reg_ctrl.sv
hdl/fm_timer.sv
hdl/fm_core_top.sv
testbench/tb_clk_gen.sv
testbench/tb_fm_core.sv

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ns

// Free-running 4 ns clock and a reset held for the first three cycles.
module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* testbench/tb_fm_core.sv */
`timescale 1ns/1ns

module tb_fm_core;

	// CPU port meaning, addr bit 0.
	localparam logic [1:0] PORT_ADDR = 2'd0;
	localparam logic [1:0] PORT_DATA = 2'd1;
	localparam logic [31:0] LFSR_SEED = 32'h6590;
	// Status busy must drop this many clk_en cycles after a data write.
	localparam int BUSY_LIMIT = fm_pkg::FM_DIV * (fm_pkg::BUSY_TICKS + 2) + 3;
	// Ticks from a control write strobe to the timer load.
	// Arrival, then the apply tick, then the load tick.
	localparam int LOAD_TICKS = 3;
	// Timer loads used by the fixed tests.
	localparam logic [9:0] DROP_LOAD = 10'h3F0;
	localparam logic [9:0] DIS_LOAD = 10'h3E0;
	// Worst-case periods in FM ticks.
	localparam int A_MAX_TICKS = 64;
	localparam int B_MAX_TICKS = 8 * fm_pkg::TMRB_PRESCALE;
	localparam int DIS_TICKS = 32;
	localparam int TIMER_TICKS = 16 + 3 * A_MAX_TICKS + B_MAX_TICKS + 2 * DIS_TICKS + 16;
	// Register writes, each waits out the busy of the one before.
	localparam int N_WRITES = 40;
	localparam int TIMEOUT_CYCLES = TIMER_TICKS * fm_pkg::FM_DIV
		+ N_WRITES * (BUSY_LIMIT + 4) + 1000;

	logic        clk;
	logic        rst;
	logic        clk_en;
	logic        cs_n;
	logic        wr_n;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic [1:0]  irq_flags;
	int unsigned cycle = 0;
	// Cycle count at the negedge after the last strobe was sampled.
	int unsigned strobe_cycle = 0;
	logic [31:0] lfsr = LFSR_SEED;
	// Random timer A load, kept for the flag clear test.
	logic [9:0]  load_a_rnd;

	tb_clk_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	fm_core_top i_fm_core_top (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.cs_n      (cs_n),
		.wr_n      (wr_n),
		.addr      (addr),
		.din       (din),
		.dout      (dout),
		.irq_flags (irq_flags)
	);

	// ##################################################
	// Cycle counter and timeout.
	// ##################################################

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle == TIMEOUT_CYCLES) begin
			$display("*** FAILED ***");
			$fatal(1, "Timeout, the run did not end within %0d cycles.", TIMEOUT_CYCLES);
		end
	end

	// ##################################################
	// Helpers.
	// ##################################################

	task automatic check_eq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Value check on %s failed.", name);
		end
	endtask

	task automatic report_failure(input string what);
		$display("*** FAILED ***");
		$fatal(1, "%s", what);
	endtask

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken.
	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [7:0] ctrl_bit(input int pos);
		return 8'd1 << pos;
	endfunction

	// FM ticks between overflows.
	function automatic int ticks_a(input logic [9:0] load);
		return (1 << fm_pkg::TMRA_W) - int'(load);
	endfunction

	function automatic int ticks_b(input logic [7:0] load);
		return ((1 << fm_pkg::TMRB_W) - int'(load)) * fm_pkg::TMRB_PRESCALE;
	endfunction

	// One cycle write strobe, ends on the negedge after it was sampled.
	task automatic strobe(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk);
		cs_n <= 1'b0;
		wr_n <= 1'b0;
		addr <= a;
		din  <= d;
		@(posedge clk);
		cs_n <= 1'b1;
		wr_n <= 1'b1;
		@(negedge clk);
		strobe_cycle = cycle;
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		@(negedge clk);
		while (dout[7] !== 1'b0) begin
			if (n > BUSY_LIMIT)
				report_failure($sformatf("Status busy stayed high for over %0d cycles.",
					BUSY_LIMIT));
			@(negedge clk);
			n++;
		end
	endtask

	task automatic cpu_write(input logic [1:0] a, input logic [7:0] d);
		wait_not_busy();
		strobe(a, d);
	endtask

	// Select a register, then write its data.
	task automatic write_reg(input logic [7:0] r, input logic [7:0] v);
		cpu_write(PORT_ADDR, r);
		cpu_write(PORT_DATA, v);
	endtask

	task automatic load_timer_a(input logic [9:0] load);
		write_reg(fm_pkg::REG_TMRA_HI, load[9:2]);
		write_reg(fm_pkg::REG_TMRA_LO, {6'd0, load[1:0]});
	endtask

	// Flag must set in a window after the control write that loaded its timer.
	task automatic expect_flag_after(input int idx, input int ticks, input logic other_exp);
		int unsigned start;
		int unsigned elapsed;
		int lo;
		int hi;
		start = strobe_cycle;
		lo = (ticks + LOAD_TICKS - 1) * fm_pkg::FM_DIV;
		hi = (ticks + LOAD_TICKS + 2) * fm_pkg::FM_DIV;
		elapsed = cycle - start;
		while (irq_flags[idx] !== 1'b1) begin
			check_eq($sformatf("irq_flags[%0d]", 1 - idx), 32'(irq_flags[1 - idx]),
				32'(other_exp));
			if (elapsed > hi)
				report_failure($sformatf("Flag %0d did not set within %0d cycles.", idx, hi));
			@(negedge clk);
			elapsed = cycle - start;
		end
		if (elapsed < lo)
			report_failure($sformatf("Flag %0d set after %0d cycles, before %0d.",
				idx, elapsed, lo));
		check_eq($sformatf("dout[%0d]", idx), 32'(dout[idx]), 32'd1);
	endtask

	// Reset bit write, then compare both flag views once the write is done.
	task automatic clear_and_check(input int rst_bit, input logic [1:0] flags_exp);
		write_reg(fm_pkg::REG_TMR_CTRL, ctrl_bit(rst_bit));
		wait_not_busy();
		check_eq("irq_flags", 32'(irq_flags), 32'(flags_exp));
		check_eq("dout", 32'(dout), 32'({6'd0, flags_exp}));
	endtask

	// ##################################################
	// Directed tests.
	// ##################################################

	task automatic test_reset_idle();
		int i;
		$display("Reset state and write with clk_en low.");
		@(negedge clk);
		check_eq("dout", 32'(dout), 32'h00);
		check_eq("irq_flags", 32'(irq_flags), 32'h0);
		strobe(PORT_DATA, 8'h5A);
		for (i = 0; i < 4; i++) begin
			check_eq("dout[7]", 32'(dout[7]), 32'd0);
			@(negedge clk);
		end
		// Ticks start, internal reset drops on the first.
		@(posedge clk);
		clk_en <= 1'b1;
		repeat (2 * fm_pkg::FM_DIV) @(posedge clk);
	endtask

	task automatic test_busy_and_drop();
		int unsigned start;
		$display("Busy timing and write dropped while busy.");
		cpu_write(PORT_ADDR, fm_pkg::REG_TMRA_HI);
		cpu_write(PORT_DATA, DROP_LOAD[9:2]);
		start = strobe_cycle;
		check_eq("dout[7]", 32'(dout[7]), 32'd1);
		// A different high byte, lost because busy is up.
		strobe(PORT_DATA, 8'hF0);
		check_eq("dout[7]", 32'(dout[7]), 32'd1);
		while (dout[7] !== 1'b0) begin
			if (cycle - start > BUSY_LIMIT)
				report_failure($sformatf("Busy did not fall within %0d cycles.", BUSY_LIMIT));
			@(negedge clk);
		end
		write_reg(fm_pkg::REG_TMRA_LO, {6'd0, DROP_LOAD[1:0]});
		write_reg(fm_pkg::REG_TMR_CTRL,
			ctrl_bit(fm_pkg::CTRL_LOAD_A) | ctrl_bit(fm_pkg::CTRL_EN_A));
		expect_flag_after(0, ticks_a(DROP_LOAD), 1'b0);
		clear_and_check(fm_pkg::CTRL_RST_A, 2'b00);
	endtask

	task automatic test_timer_a_period();
		logic [31:0] r;
		take_bits(6, r);
		load_a_rnd = {4'hF, r[5:0]};
		$display("Timer A load 0x%0h.", load_a_rnd);
		load_timer_a(load_a_rnd);
		write_reg(fm_pkg::REG_TMR_CTRL,
			ctrl_bit(fm_pkg::CTRL_LOAD_A) | ctrl_bit(fm_pkg::CTRL_EN_A));
		expect_flag_after(0, ticks_a(load_a_rnd), 1'b0);
		clear_and_check(fm_pkg::CTRL_RST_A, 2'b00);
	endtask

	// Flag B is left set for the clear test.
	task automatic test_timer_b_period();
		logic [31:0] r;
		logic [7:0]  load_b;
		take_bits(3, r);
		load_b = {5'h1F, r[2:0]};
		$display("Timer B load 0x%0h.", load_b);
		write_reg(fm_pkg::REG_TMRB, load_b);
		write_reg(fm_pkg::REG_TMR_CTRL,
			ctrl_bit(fm_pkg::CTRL_LOAD_B) | ctrl_bit(fm_pkg::CTRL_EN_B));
		expect_flag_after(1, ticks_b(load_b), 1'b0);
	endtask

	// Each reset bit is written while the other flag is set.
	task automatic test_flag_clear();
		$display("Flag clear leaves the other flag alone.");
		write_reg(fm_pkg::REG_TMR_CTRL, ctrl_bit(fm_pkg::CTRL_LOAD_A)
			| ctrl_bit(fm_pkg::CTRL_EN_A) | ctrl_bit(fm_pkg::CTRL_EN_B));
		expect_flag_after(0, ticks_a(load_a_rnd), 1'b1);
		clear_and_check(fm_pkg::CTRL_RST_A, 2'b10);
		// Flag A set again, flag B still set.
		write_reg(fm_pkg::REG_TMR_CTRL,
			ctrl_bit(fm_pkg::CTRL_LOAD_A) | ctrl_bit(fm_pkg::CTRL_EN_A));
		expect_flag_after(0, ticks_a(load_a_rnd), 1'b1);
		clear_and_check(fm_pkg::CTRL_RST_B, 2'b01);
		clear_and_check(fm_pkg::CTRL_RST_A, 2'b00);
	endtask

	task automatic test_disabled_timer();
		int n;
		$display("Loaded timer A with its enable off.");
		load_timer_a(DIS_LOAD);
		write_reg(fm_pkg::REG_TMR_CTRL, ctrl_bit(fm_pkg::CTRL_LOAD_A));
		// Two full periods past the load.
		n = (2 * ticks_a(DIS_LOAD) + LOAD_TICKS + 2) * fm_pkg::FM_DIV;
		repeat (n) begin
			@(negedge clk);
			check_eq("irq_flags[0]", 32'(irq_flags[0]), 32'd0);
		end
	endtask

	initial begin
		clk_en = 1'b0;
		cs_n   = 1'b1;
		wr_n   = 1'b1;
		addr   = 2'd0;
		din    = 8'd0;
		wait (rst === 1'b0);
		test_reset_idle();
		test_busy_and_drop();
		test_timer_a_period();
		test_timer_b_period();
		test_flag_clear();
		test_disabled_timer();
		$display("*** PASSED ***");
		$finish;
	end

endmodule
